//--- common/t05_huff_params.svh
`ifndef T05_HUFF_PARAMS_SVH
`define T05_HUFF_PARAMS_SVH

// Longest Huffman path the codebook may hold, in bits
`define T05_MAX_CODE_LEN 12

// Number of items in the code FIFO
// Must be a power of two
`define T05_FIFO_DEPTH 4

// Width of the per-file character count
`define T05_COUNT_W 16

`endif

//--- common/t05_huff_pkg.sv
`default_nettype none

`include "t05_huff_params.svh"

package t05_huff_pkg;

  // One codebook entry, 16 bits in all
  // Path is right-aligned with the first bit to send at len-1
  typedef struct packed {
    logic [3:0]                   len;
    logic [`T05_MAX_CODE_LEN-1:0] path;
  } code_t;

  // Input stream beat
  // Symbol is don't-care when eof is set
  typedef struct packed {
    logic       eof;
    logic [7:0] symbol;
  } sym_beat_t;

  typedef enum logic {
    item_code  = 1'b0,
    item_count = 1'b1
  } item_kind_e;

  // Same 16-bit word seen as a code or as the trailer count
  typedef union packed {
    code_t                   code;
    logic [`T05_COUNT_W-1:0] count;
  } item_body_u;

  typedef struct packed {
    item_kind_e kind;
    item_body_u body;
  } fifo_item_t;

endpackage

`default_nettype wire

//--- hw/translation/t05_translation.sv
`timescale 1ns/100ps
`default_nettype none

`include "t05_huff_params.svh"

module t05_translation (
  input  logic                     clk,
  input  logic                     reset,

  // Codebook load port
  input  logic                     cb_we,
  input  logic [7:0]               cb_char,
  input  t05_huff_pkg::code_t      cb_code,

  // Character stream in
  input  t05_huff_pkg::sym_beat_t  char_in,
  input  logic                     char_valid,
  output logic                     char_ready,

  // Code items out
  output t05_huff_pkg::fifo_item_t item,
  output logic                     item_valid,
  input  logic                     item_ready
);

  // 256-entry table indexed by character
  t05_huff_pkg::code_t codebook [0:255];

  t05_huff_pkg::code_t     lookup;
  logic [`T05_COUNT_W-1:0] char_count;
  logic                    accept;

  // Output register is free or drains this cycle
  assign char_ready = !item_valid || item_ready;
  assign accept     = char_valid && char_ready;

  assign lookup = codebook[char_in.symbol];

  always_ff @(posedge clk) begin
    if (cb_we) begin
      codebook[cb_char] <= cb_code;
    end
  end

  // Valid flag and running count
  always_ff @(posedge clk) begin
    if (reset) begin
      item_valid <= 1'b0;
      char_count <= '0;
    end else begin
      if (accept) begin
        item_valid <= 1'b1;
        if (char_in.eof) begin
          char_count <= '0;
        end else begin
          char_count <= char_count + 1'b1;
        end
      end else if (item_ready) begin
        item_valid <= 1'b0;
      end
    end
  end

  // Item payload loaded on every accepted beat
  always_ff @(posedge clk) begin
    if (accept) begin
      if (char_in.eof) begin
        // Trailer carries the number of characters in this file
        item.kind       <= t05_huff_pkg::item_count;
        item.body.count <= char_count;
      end else begin
        item.kind      <= t05_huff_pkg::item_code;
        item.body.code <= lookup;
      end
    end
  end

  // A character accepted now must come out with a loaded code
  a_code_loaded: assert property (
    @(posedge clk) disable iff (reset)
    accept && !char_in.eof |=> item.body.code.len != 4'd0
  ) else $error("character %0d has an empty codebook entry", $past(char_in.symbol));

  // Count must not wrap back to zero on a character
  a_count_no_wrap: assert property (
    @(posedge clk) disable iff (reset)
    accept && !char_in.eof |=> char_count != '0
  ) else $error("character count overflowed");

endmodule

`default_nettype wire

//--- hw/t05_code_fifo.sv
`timescale 1ns/100ps
`default_nettype none

`include "t05_huff_params.svh"

module t05_code_fifo #(
  parameter int unsigned DEPTH = `T05_FIFO_DEPTH
) (
  input  logic                     clk,
  input  logic                     reset,

  input  t05_huff_pkg::fifo_item_t in_item,
  input  logic                     in_valid,
  output logic                     in_ready,

  output t05_huff_pkg::fifo_item_t out_item,
  output logic                     out_valid,
  input  logic                     out_ready
);

  localparam int unsigned PTR_W = $clog2(DEPTH);

  t05_huff_pkg::fifo_item_t mem [0:DEPTH-1];

  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W:0]   occupancy;
  logic             do_write;
  logic             do_read;

  assign in_ready  = occupancy != (PTR_W+1)'(DEPTH);
  assign out_valid = occupancy != '0;
  assign out_item  = mem[rd_ptr];

  assign do_write = in_valid && in_ready;
  assign do_read  = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wr_ptr] <= in_item;
    end
  end

  // Pointers wrap naturally since depth is a power of two
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr    <= '0;
      wr_ptr    <= '0;
      occupancy <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_write, do_read})
        2'b10:   occupancy <= occupancy + 1'b1;
        2'b01:   occupancy <= occupancy - 1'b1;
        default: occupancy <= occupancy;
      endcase
    end
  end

  // Write pointer runs ahead of the read pointer by the occupancy only
  a_no_write_full: assert property (
    @(posedge clk) disable iff (reset)
    occupancy <= (PTR_W+1)'(DEPTH) && PTR_W'(wr_ptr - rd_ptr) == occupancy[PTR_W-1:0]
  ) else $error("code FIFO written while full");

  // Every item read out must have been written before
  a_no_read_empty: assert property (
    @(posedge clk) disable iff (reset)
    do_read |-> !$isunknown(out_item)
  ) else $error("code FIFO read while empty");

endmodule

`default_nettype wire

//--- hw/packer/t05_byte_packer.sv
`timescale 1ns/100ps
`default_nettype none

`include "t05_huff_params.svh"

module t05_byte_packer (
  input  logic                     clk,
  input  logic                     reset,

  input  t05_huff_pkg::fifo_item_t item,
  input  logic                     item_valid,
  output logic                     item_ready,

  output logic [7:0]               byte_out,
  output logic                     byte_valid,
  input  logic                     byte_ready
);

  // Seven leftover bits plus one full-length path
  localparam int unsigned ACC_W = `T05_MAX_CODE_LEN + 7;
  localparam int unsigned CNT_W = $clog2(ACC_W + 1);

  typedef enum logic [1:0] {
    st_idle,
    st_pad,
    st_hi,
    st_lo
  } state_e;

  state_e                       state;
  // Left-aligned with the oldest bit at the top
  logic [ACC_W-1:0]             acc;
  logic [CNT_W-1:0]             acc_n;
  logic [`T05_COUNT_W-1:0]      count_q;

  t05_huff_pkg::code_t          code;
  logic [`T05_MAX_CODE_LEN-1:0] left_path;
  logic [ACC_W-1:0]             appended;
  logic                         item_take;
  logic                         byte_take;

  assign code = item.body.code;

  // Move the path to the top, then place it behind the bits already held
  assign left_path = code.path << (`T05_MAX_CODE_LEN - code.len);
  assign appended  = {left_path, {(ACC_W - `T05_MAX_CODE_LEN){1'b0}}} >> acc_n;

  // Codes and the trailer both wait until no full byte is pending
  assign item_ready = (state == st_idle) && (acc_n < CNT_W'(8));
  assign item_take  = item_valid && item_ready;
  assign byte_take  = byte_valid && byte_ready;

  always_comb begin
    case (state)
      st_hi:   byte_out = count_q[`T05_COUNT_W-1 -: 8];
      st_lo:   byte_out = count_q[7:0];
      default: byte_out = acc[ACC_W-1 -: 8];
    endcase
  end

  assign byte_valid = (state == st_idle) ? (acc_n >= CNT_W'(8)) : 1'b1;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      acc   <= '0;
      acc_n <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (item_take) begin
            if (item.kind == t05_huff_pkg::item_code) begin
              acc   <= acc | appended;
              acc_n <= acc_n + CNT_W'(code.len);
            end else if (acc_n != '0) begin
              state <= st_pad;
            end else begin
              state <= st_hi;
            end
          end else if (byte_take) begin
            acc   <= acc << 8;
            acc_n <= acc_n - CNT_W'(8);
          end
        end
        st_pad: begin
          // Bits below acc_n are already zero and form the pad
          if (byte_take) begin
            acc   <= '0;
            acc_n <= '0;
            state <= st_hi;
          end
        end
        st_hi: begin
          if (byte_take) begin
            state <= st_lo;
          end
        end
        default: begin
          if (byte_take) begin
            state <= st_idle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (item_take && item.kind == t05_huff_pkg::item_count) begin
      count_q <= item.body.count;
    end
  end

  // Stalled byte holds until the consumer takes it
  a_byte_stable: assert property (
    @(posedge clk) disable iff (reset)
    byte_valid && !byte_ready |=> byte_valid && $stable(byte_out)
  ) else $error("byte_out changed while stalled");

endmodule

`default_nettype wire

//--- hw/t05_huff_encoder.sv
`timescale 1ns/100ps
`default_nettype none

`include "t05_huff_params.svh"

module t05_huff_encoder (
  input  logic                    hwclk,
  input  logic                    reset,

  // Codebook load
  input  logic                    cb_we,
  input  logic [7:0]              cb_char,
  input  t05_huff_pkg::code_t     cb_code,

  // Characters in
  input  t05_huff_pkg::sym_beat_t char_in,
  input  logic                    char_valid,
  output logic                    char_ready,

  // Packed bytes out
  output logic [7:0]              byte_out,
  output logic                    byte_valid,
  input  logic                    byte_ready
);

  t05_huff_pkg::fifo_item_t tr_item;
  logic                     tr_valid;
  logic                     tr_ready;

  t05_huff_pkg::fifo_item_t fifo_item;
  logic                     fifo_valid;
  logic                     fifo_ready;

  t05_translation translation (
    .clk(hwclk), .reset(reset),
    .cb_we(cb_we), .cb_char(cb_char), .cb_code(cb_code),
    .char_in(char_in), .char_valid(char_valid), .char_ready(char_ready),
    .item(tr_item), .item_valid(tr_valid), .item_ready(tr_ready)
  );

  t05_code_fifo #(
    .DEPTH(`T05_FIFO_DEPTH)
  ) code_fifo (
    .clk(hwclk), .reset(reset),
    .in_item(tr_item), .in_valid(tr_valid), .in_ready(tr_ready),
    .out_item(fifo_item), .out_valid(fifo_valid), .out_ready(fifo_ready)
  );

  t05_byte_packer byte_packer (
    .clk(hwclk), .reset(reset),
    .item(fifo_item), .item_valid(fifo_valid), .item_ready(fifo_ready),
    .byte_out(byte_out), .byte_valid(byte_valid), .byte_ready(byte_ready)
  );

endmodule

`default_nettype wire

//--- tb/t05_huff_encoder_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "t05_huff_params.svh"

module t05_huff_encoder_tb;

  localparam int WAIT_LIMIT = 200;

  logic                    clk;
  logic                    reset;
  logic                    cb_we;
  logic [7:0]              cb_char;
  t05_huff_pkg::code_t     cb_code;
  t05_huff_pkg::sym_beat_t char_in;
  logic                    char_valid;
  logic                    char_ready;
  logic [7:0]              byte_out;
  logic                    byte_valid;
  logic                    byte_ready;

  // Contents of the vector file
  logic [7:0]              load_chars [$];
  t05_huff_pkg::code_t     load_codes [$];
  t05_huff_pkg::sym_beat_t beats [$];
  logic [7:0]              exp_bytes [$];
  logic [`T05_COUNT_W-1:0] exp_counts [$];
  int                      exp_data_bytes [$];

  int          mismatches;
  int          failures;
  int          pass;
  logic [15:0] lfsr;
  logic        random_ready;

  t05_huff_encoder u_t05_huff_encoder (
    .hwclk(clk), .reset(reset),
    .cb_we(cb_we), .cb_char(cb_char), .cb_code(cb_code),
    .char_in(char_in), .char_valid(char_valid), .char_ready(char_ready),
    .byte_out(byte_out), .byte_valid(byte_valid), .byte_ready(byte_ready)
  );

  always begin
    #10 clk = ~clk;
  end

  // Galois form of x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    lfsr_next = state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
  endfunction

  task automatic finish_run();
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  task automatic timed_out(input string what);
    $display("timeout at %0t while waiting for %s", $time, what);
    failures++;
    finish_run();
  endtask

  task automatic check_byte(input string name, input logic [7:0] expected,
                            input logic [7:0] actual);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
      mismatches++;
    end
  endtask

  task automatic check_count(input string name, input logic [`T05_COUNT_W-1:0] expected,
                             input logic [`T05_COUNT_W-1:0] actual);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s expected %0d got %0d", $time, name, expected, actual);
      mismatches++;
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s expected %b got %b", $time, name, expected, actual);
      mismatches++;
    end
  endtask

  task automatic read_vectors();
    int                      fd;
    int                      n;
    int                      unused;
    int                      ch;
    int                      len;
    int                      path;
    int                      value;
    int                      count;
    int                      bits;
    int                      code_len [0:255];
    logic [8*8-1:0]          tag;
    logic [8*8-1:0]          tok;
    logic [8*128-1:0]        line;
    t05_huff_pkg::code_t     code;
    t05_huff_pkg::sym_beat_t beat;
    count = 0;
    bits = 0;
    for (int i = 0; i < 256; i++) begin
      code_len[i] = 0;
    end
    fd = $fopen("tb/t05_huff_vectors.txt", "r");
    if (fd == 0) begin
      $display("cannot open the vector file tb/t05_huff_vectors.txt");
      failures++;
      finish_run();
    end else begin
      n = $fscanf(fd, "%s", tag);
      while (n == 1) begin
        if (tag == "#") begin
          unused = $fgets(line, fd);
        end else if (tag == "L") begin
          unused = $fscanf(fd, "%h %d %h", ch, len, path);
          code.len = len[3:0];
          code.path = path[`T05_MAX_CODE_LEN-1:0];
          load_chars.push_back(ch[7:0]);
          load_codes.push_back(code);
          code_len[ch[7:0]] = len;
        end else if (tag == "C") begin
          unused = $fscanf(fd, "%s", tok);
          beat.eof = (tok == "E");
          beat.symbol = 8'h00;
          if (beat.eof) begin
            // Expected trailer and data length of the file just ended
            exp_counts.push_back(count[`T05_COUNT_W-1:0]);
            exp_data_bytes.push_back((bits + 7) / 8);
            count = 0;
            bits = 0;
          end else begin
            unused = $sscanf(tok, "%h", ch);
            beat.symbol = ch[7:0];
            count++;
            bits += code_len[ch[7:0]];
          end
          beats.push_back(beat);
        end else if (tag == "B") begin
          unused = $fscanf(fd, "%h", value);
          exp_bytes.push_back(value[7:0]);
        end else begin
          $display("unknown line kind %s in the vector file", tag);
          failures++;
        end
        n = $fscanf(fd, "%s", tag);
      end
      $fclose(fd);
    end
  endtask

  task automatic apply_reset();
    @(negedge clk);
    reset = 1'b1;
    repeat (10) @(negedge clk);
    reset = 1'b0;
  endtask

  // Idle outputs right after reset
  task automatic check_idle();
    repeat (3) begin
      @(negedge clk);
      check_flag("byte_valid", 1'b0, byte_valid);
      check_flag("char_ready", 1'b1, char_ready);
    end
  endtask

  task automatic load_codebook();
    for (int i = 0; i < load_chars.size(); i++) begin
      @(negedge clk);
      cb_we = 1'b1;
      cb_char = load_chars[i];
      cb_code = load_codes[i];
    end
    @(negedge clk);
    cb_we = 1'b0;
  endtask

  task automatic send_stream();
    int cycles;
    for (int i = 0; i < beats.size(); i++) begin
      @(negedge clk);
      char_in = beats[i];
      char_valid = 1'b1;
      cycles = 0;
      while (!char_ready && cycles < WAIT_LIMIT) begin
        @(negedge clk);
        cycles++;
      end
      if (!char_ready) begin
        timed_out("char_ready");
      end else begin
        @(posedge clk);
      end
    end
    @(negedge clk);
    char_valid = 1'b0;
  endtask

  // One byte taken at the edge after the negedge where both flags are high
  task automatic recv_byte(output logic [7:0] data);
    int   cycles;
    logic got;
    got = 1'b0;
    cycles = 0;
    data = 8'h00;
    while (!got && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      if (random_ready) begin
        byte_ready = lfsr[0];
        lfsr = lfsr_next(lfsr);
      end else begin
        byte_ready = 1'b1;
      end
      if (byte_valid && byte_ready) begin
        data = byte_out;
        got = 1'b1;
      end
      cycles++;
    end
    if (!got) begin
      timed_out("byte_valid");
    end
  endtask

  task automatic expect_byte(input int k, input logic [7:0] data);
    if (k < exp_bytes.size()) begin
      check_byte("byte_out", exp_bytes[k], data);
    end else begin
      $display("output byte %0d has no B line in the vector file", k);
      failures++;
    end
  endtask

  task automatic collect_output();
    int         k;
    logic [7:0] data;
    logic [7:0] hi;
    logic [7:0] lo;
    k = 0;
    for (int f = 0; f < exp_counts.size(); f++) begin
      for (int i = 0; i < exp_data_bytes[f]; i++) begin
        recv_byte(data);
        expect_byte(k, data);
        k++;
      end
      recv_byte(hi);
      expect_byte(k, hi);
      recv_byte(lo);
      expect_byte(k + 1, lo);
      k += 2;
      check_count("count bytes", exp_counts[f], {hi, lo});
    end
    if (k != exp_bytes.size()) begin
      $display("vector file lists %0d bytes but the stream gives %0d", exp_bytes.size(), k);
      failures++;
    end
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    cb_we = 1'b0;
    cb_char = 8'h00;
    cb_code = '0;
    char_in = '0;
    char_valid = 1'b0;
    byte_ready = 1'b0;
    mismatches = 0;
    failures = 0;
    lfsr = 16'd13491;
    random_ready = 1'b0;
    read_vectors();
    // First pass without stalls and second with random byte_ready
    for (pass = 0; pass < 2; pass++) begin
      random_ready = (pass == 1);
      byte_ready = 1'b0;
      apply_reset();
      check_idle();
      load_codebook();
      fork
        send_stream();
        collect_output();
      join
      @(negedge clk);
      byte_ready = 1'b1;
      repeat (6) @(negedge clk);
      check_flag("byte_valid", 1'b0, byte_valid);
    end
    finish_run();
  end

endmodule

`default_nettype wire

//--- tb/t05_huff_vectors.txt
# L char len path : codebook load, C char or E : input beat, B byte : expected output
# Values in hex except len, which is decimal
L 61 1 000
L 62 3 005
L 63 5 019
L 64 12 a5c
L 65 7 073
L 66 2 003
C 61
C 62
C 63
C 64
C 65
C 66
C 61
C E
B 5c
B d2
B e7
B 3c
B 00
B 07
C 64
C 66
C 62
C 63
C 65
C 61
C 61
C 61
C E
B a5
B ce
B e7
B 98
B 00
B 08
C E
B 00
B 00

//--- verilog.f
+incdir+common
common/t05_huff_pkg.sv
hw/translation/t05_translation.sv
hw/t05_code_fifo.sv
hw/packer/t05_byte_packer.sv
hw/t05_huff_encoder.sv
tb/t05_huff_encoder_tb.sv

//--- Bender.yml
package:
  name: t05_huff_encoder

sources:
  - include_dirs:
      - common
    files:
      - common/t05_huff_pkg.sv
      - hw/translation/t05_translation.sv
      - hw/t05_code_fifo.sv
      - hw/packer/t05_byte_packer.sv
      - hw/t05_huff_encoder.sv
  - target: test
    include_dirs:
      - common
    files:
      - tb/t05_huff_encoder_tb.sv
